// ==== design/rv_decode_pkg.sv ====
package rv_decode_pkg;

    ////////////////////
    // Widths

    // Data path and instruction word width
    localparam int XLEN = 32;

    // Register index width and register count
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    ////////////////////
    // Major opcodes

    // LUI; AUIPC is the same pattern with bit 5 clear
    localparam logic [6:0] OPC_UPPER  = 7'b0110111;

    // JAL; JALR is the same pattern with bit 3 clear
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // BEQ BNE BLT BGE BLTU BGEU
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // LB LH LW LBU LHU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    // SB SH SW
    // Differs from a load only in bit 5
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ADDI SLTI SLTIU XORI ORI ANDI and the immediate shifts
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // Register to register ALU operations
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    ////////////////////
    // Execution units

    // Selects the block downstream that executes the instruction
    // Code 7 is never produced
    typedef enum logic [2:0] {
        UNIT_UPPER,
        UNIT_JUMP,
        UNIT_BRANCH,
        UNIT_MEM,
        UNIT_ALU_IMM,
        UNIT_ALU_REG,
        UNIT_ILLEGAL
    } unit_t;

    ////////////////////
    // Start up

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // PC tagged onto the NOP after reset
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;

endpackage

// ==== design/fetch_capture.sv ====
`timescale 1ns/1ps

module fetch_capture (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_fetch_valid,
    input  logic [rv_decode_pkg::XLEN-1:0]  i_fetch_instr,
    input  logic [rv_decode_pkg::XLEN-1:0]  i_fetch_pc,
    output logic                            o_valid,
    output logic [rv_decode_pkg::XLEN-1:0]  o_instr,
    output logic [rv_decode_pkg::XLEN-1:0]  o_pc
);
    import rv_decode_pkg::*;

    // High from reset until the first edge after release
    logic nop_pending;

    // Strobe and injection flag
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            nop_pending <= 1'b1;
            o_valid     <= 1'b0;
        end
        else
        begin
            nop_pending <= 1'b0;
            // The NOP takes the slot, any fetch on this edge is lost
            o_valid     <= nop_pending | i_fetch_valid;
        end
    end

    // Word and PC
    always_ff @(posedge i_clk)
    begin
        if (nop_pending)
        begin
            o_instr <= NOP_WORD;
            o_pc    <= RESET_VECTOR;
        end
        else if (i_fetch_valid)
        begin
            o_instr <= i_fetch_instr;
            o_pc    <= i_fetch_pc;
        end
    end

endmodule

// ==== design/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_instr,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_pc,
    output logic                                   o_valid,
    output rv_decode_pkg::unit_t                   o_unit,
    output logic                                   o_iop,
    output logic        [2:0]                      o_funct3,
    output logic  [rv_decode_pkg::REG_ADDR_W-1:0]  o_rd,
    output logic  [rv_decode_pkg::REG_ADDR_W-1:0]  o_rs1,
    output logic  [rv_decode_pkg::REG_ADDR_W-1:0]  o_rs2,
    output logic                                   o_rs1_used,
    output logic                                   o_rs2_used,
    output logic signed [rv_decode_pkg::XLEN-1:0]  o_imm,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_pc
);
    import rv_decode_pkg::*;

    // Raw instruction fields
    logic [6:0]            opcode;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [REG_ADDR_W-1:0] rs1_field;
    logic [REG_ADDR_W-1:0] rs2_field;

    // Sign extended immediates, one per format
    logic signed [XLEN-1:0] imm_i;
    logic signed [XLEN-1:0] imm_s;
    logic signed [XLEN-1:0] imm_b;
    logic signed [XLEN-1:0] imm_u;
    logic signed [XLEN-1:0] imm_j;

    // Decoded values ahead of the output register
    unit_t                  unit_d;
    logic                   iop_d;
    logic [2:0]             funct3_d;
    logic [REG_ADDR_W-1:0]  rd_d;
    logic [REG_ADDR_W-1:0]  rs1_d;
    logic [REG_ADDR_W-1:0]  rs2_d;
    logic                   rs1_used_d;
    logic                   rs2_used_d;
    logic signed [XLEN-1:0] imm_d;

    assign opcode    = i_instr[6:0];
    assign rd_field  = i_instr[11:7];
    assign rs1_field = i_instr[19:15];
    assign rs2_field = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    ////////////////////
    // Family select

    // Upper and jump groups ignore the bit that tells their two members apart
    always_comb
    begin
        if ({opcode[6], opcode[4:0]} == {OPC_UPPER[6], OPC_UPPER[4:0]})
            unit_d = UNIT_UPPER;
        else if ({opcode[6:4], opcode[2:0]} == {OPC_JAL[6:4], OPC_JAL[2:0]})
            unit_d = UNIT_JUMP;
        else
        begin
            case (opcode)
                OPC_BRANCH:          unit_d = UNIT_BRANCH;
                OPC_LOAD, OPC_STORE: unit_d = UNIT_MEM;
                OPC_OP_IMM:          unit_d = UNIT_ALU_IMM;
                OPC_OP:              unit_d = UNIT_ALU_REG;
                // CSR, fence, system and anything unknown
                default:             unit_d = UNIT_ILLEGAL;
            endcase
        end
    end

    ////////////////////
    // Fields per family

    always_comb
    begin
        // Everything zero unless the family uses it
        iop_d      = 1'b0;
        funct3_d   = i_instr[14:12];
        rd_d       = '0;
        rs1_d      = '0;
        rs2_d      = '0;
        rs1_used_d = 1'b0;
        rs2_used_d = 1'b0;
        imm_d      = '0;
        case (unit_d)
            UNIT_UPPER:
            begin
                // Bit 5 set for LUI
                iop_d = i_instr[5];
                rd_d  = rd_field;
                imm_d = imm_u;
            end
            UNIT_JUMP:
            begin
                // Bit 3 set for JAL
                iop_d = i_instr[3];
                rd_d  = rd_field;
                imm_d = imm_j;
            end
            UNIT_BRANCH:
            begin
                rs1_d      = rs1_field;
                rs2_d      = rs2_field;
                rs1_used_d = 1'b1;
                rs2_used_d = 1'b1;
                imm_d      = imm_b;
            end
            UNIT_MEM:
            begin
                // Bit 5 marks a store
                iop_d      = i_instr[5];
                rs1_d      = rs1_field;
                rs1_used_d = 1'b1;
                if (i_instr[5])
                begin
                    rs2_d      = rs2_field;
                    rs2_used_d = 1'b1;
                    imm_d      = imm_s;
                end
                else
                begin
                    rd_d  = rd_field;
                    imm_d = imm_i;
                end
            end
            UNIT_ALU_IMM:
            begin
                // SRAI against SRLI
                iop_d      = i_instr[30];
                rd_d       = rd_field;
                rs1_d      = rs1_field;
                rs1_used_d = 1'b1;
                imm_d      = imm_i;
            end
            UNIT_ALU_REG:
            begin
                // SUB and SRA
                iop_d      = i_instr[30];
                rd_d       = rd_field;
                rs1_d      = rs1_field;
                rs2_d      = rs2_field;
                rs1_used_d = 1'b1;
                rs2_used_d = 1'b1;
            end
            default:
            begin
                funct3_d = '0;
            end
        endcase
    end

    // Output strobe
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    // Decoded bundle
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_unit     <= unit_d;
            o_iop      <= iop_d;
            o_funct3   <= funct3_d;
            o_rd       <= rd_d;
            o_rs1      <= rs1_d;
            o_rs2      <= rs2_d;
            o_rs1_used <= rs1_used_d;
            o_rs2_used <= rs2_used_d;
            o_imm      <= imm_d;
            o_pc       <= i_pc;
        end
    end

endmodule

// ==== design/operand_read.sv ====
`timescale 1ns/1ps

module operand_read (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  rv_decode_pkg::unit_t                   i_unit,
    input  logic                                   i_iop,
    input  logic        [2:0]                      i_funct3,
    input  logic  [rv_decode_pkg::REG_ADDR_W-1:0]  i_rd,
    input  logic  [rv_decode_pkg::REG_ADDR_W-1:0]  i_rs1,
    input  logic  [rv_decode_pkg::REG_ADDR_W-1:0]  i_rs2,
    input  logic                                   i_rs1_used,
    input  logic                                   i_rs2_used,
    input  logic signed [rv_decode_pkg::XLEN-1:0]  i_imm,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_pc,
    input  logic                                   i_wb_valid,
    input  logic  [rv_decode_pkg::REG_ADDR_W-1:0]  i_wb_rd,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_wb_data,
    output logic                                   o_issue_valid,
    output rv_decode_pkg::unit_t                   o_issue_unit,
    output logic                                   o_issue_iop,
    output logic        [2:0]                      o_issue_funct3,
    output logic  [rv_decode_pkg::REG_ADDR_W-1:0]  o_issue_rd,
    output logic signed [rv_decode_pkg::XLEN-1:0]  o_issue_imm,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_issue_pc,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_issue_rs1_data,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_issue_rs2_data
);
    import rv_decode_pkg::*;

    // Entry 0 is never written
    logic [XLEN-1:0] reg_file [NUM_REGS];

    // Read data ahead of the issue register
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // One read port with x0, use flag and writeback bypass
    function automatic logic [XLEN-1:0] read_port(
        input logic                  used,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       stored,
        input logic                  wb_valid,
        input logic [REG_ADDR_W-1:0] wb_rd,
        input logic [XLEN-1:0]       wb_data
    );
        if (!used || addr == '0)
            return '0;
        else if (wb_valid && wb_rd == addr)
            return wb_data;
        else
            return stored;
    endfunction

    ////////////////////
    // Register file

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            for (int r = 0; r < NUM_REGS; r++)
            begin
                reg_file[r] <= '0;
            end
        end
        // x0 stays zero
        else if (i_wb_valid && i_wb_rd != '0)
        begin
            reg_file[i_wb_rd] <= i_wb_data;
        end
    end

    always_comb
    begin
        rs1_data = read_port(i_rs1_used, i_rs1, reg_file[i_rs1],
                             i_wb_valid, i_wb_rd, i_wb_data);
        rs2_data = read_port(i_rs2_used, i_rs2, reg_file[i_rs2],
                             i_wb_valid, i_wb_rd, i_wb_data);
    end

    ////////////////////
    // Issue register

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            o_issue_valid <= 1'b0;
        else
            o_issue_valid <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_issue_unit     <= i_unit;
            o_issue_iop      <= i_iop;
            o_issue_funct3   <= i_funct3;
            o_issue_rd       <= i_rd;
            o_issue_imm      <= i_imm;
            o_issue_pc       <= i_pc;
            o_issue_rs1_data <= rs1_data;
            o_issue_rs2_data <= rs2_data;
        end
    end

endmodule

// ==== design/decode_stage_top.sv ====
`timescale 1ns/1ps

module decode_stage_top (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    // Fetch side
    input  logic                                   i_fetch_valid,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_fetch_instr,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_fetch_pc,
    // Writeback side
    input  logic                                   i_wb_valid,
    input  logic  [rv_decode_pkg::REG_ADDR_W-1:0]  i_wb_rd,
    input  logic        [rv_decode_pkg::XLEN-1:0]  i_wb_data,
    // Issue side
    output logic                                   o_issue_valid,
    output rv_decode_pkg::unit_t                   o_issue_unit,
    output logic                                   o_issue_iop,
    output logic        [2:0]                      o_issue_funct3,
    output logic  [rv_decode_pkg::REG_ADDR_W-1:0]  o_issue_rd,
    output logic signed [rv_decode_pkg::XLEN-1:0]  o_issue_imm,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_issue_pc,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_issue_rs1_data,
    output logic        [rv_decode_pkg::XLEN-1:0]  o_issue_rs2_data
);
    import rv_decode_pkg::*;

    // Capture to decoder
    logic            cap_valid;
    logic [XLEN-1:0] cap_instr;
    logic [XLEN-1:0] cap_pc;

    // Decoder to operand read
    logic                   dec_valid;
    unit_t                  dec_unit;
    logic                   dec_iop;
    logic [2:0]             dec_funct3;
    logic [REG_ADDR_W-1:0]  dec_rd;
    logic [REG_ADDR_W-1:0]  dec_rs1;
    logic [REG_ADDR_W-1:0]  dec_rs2;
    logic                   dec_rs1_used;
    logic                   dec_rs2_used;
    logic signed [XLEN-1:0] dec_imm;
    logic [XLEN-1:0]        dec_pc;

    fetch_capture u_capture (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_instr (i_fetch_instr),
        .i_fetch_pc    (i_fetch_pc),
        .o_valid       (cap_valid),
        .o_instr       (cap_instr),
        .o_pc          (cap_pc)
    );

    instruction_decoder u_decoder (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (cap_valid),
        .i_instr    (cap_instr),
        .i_pc       (cap_pc),
        .o_valid    (dec_valid),
        .o_unit     (dec_unit),
        .o_iop      (dec_iop),
        .o_funct3   (dec_funct3),
        .o_rd       (dec_rd),
        .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2),
        .o_rs1_used (dec_rs1_used),
        .o_rs2_used (dec_rs2_used),
        .o_imm      (dec_imm),
        .o_pc       (dec_pc)
    );

    operand_read u_operands (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_valid          (dec_valid),
        .i_unit           (dec_unit),
        .i_iop            (dec_iop),
        .i_funct3         (dec_funct3),
        .i_rd             (dec_rd),
        .i_rs1            (dec_rs1),
        .i_rs2            (dec_rs2),
        .i_rs1_used       (dec_rs1_used),
        .i_rs2_used       (dec_rs2_used),
        .i_imm            (dec_imm),
        .i_pc             (dec_pc),
        .i_wb_valid       (i_wb_valid),
        .i_wb_rd          (i_wb_rd),
        .i_wb_data        (i_wb_data),
        .o_issue_valid    (o_issue_valid),
        .o_issue_unit     (o_issue_unit),
        .o_issue_iop      (o_issue_iop),
        .o_issue_funct3   (o_issue_funct3),
        .o_issue_rd       (o_issue_rd),
        .o_issue_imm      (o_issue_imm),
        .o_issue_pc       (o_issue_pc),
        .o_issue_rs1_data (o_issue_rs1_data),
        .o_issue_rs2_data (o_issue_rs2_data)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk
);

    // Half of the 100 ns period
    localparam int HALF_PERIOD_NS = 50;

    // Free running, starts low so the first rising edge is at 50 ns
    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD_NS);
            o_clk = ~o_clk;
        end
    end

endmodule

// ==== tb/decode_assert.sv ====
`timescale 1ns/1ps

module decode_assert (
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_cap_valid,
    input logic       i_issue_valid,
    input logic [2:0] i_issue_unit
);
    import rv_decode_pkg::*;

    // Issue side stays quiet while reset is held
    reset_quiet: assert property (@(posedge i_clk) i_reset |-> !i_issue_valid)
        else $error("Issue strobe high during reset");

    // Fetch or NOP shows up on the capture strobe
    // Decoder and operand read add two more edges
    issue_latency: assert property (@(posedge i_clk) disable iff (i_reset)
        i_issue_valid == $past(i_cap_valid, 2))
        else $error("Issue strobe out of step with the capture strobe");

    // Code 7 has no unit behind it
    unit_defined: assert property (@(posedge i_clk) disable iff (i_reset)
        i_issue_valid |-> (i_issue_unit <= 3'(UNIT_ILLEGAL)))
        else $error("Issue unit holds an undefined code");

endmodule

bind decode_stage_top decode_assert u_assert (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_cap_valid   (cap_valid),
    .i_issue_valid (o_issue_valid),
    .i_issue_unit  (o_issue_unit)
);

// ==== tb/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
    import rv_decode_pkg::*;

    localparam int unsigned SEED         = 32'hf2a628e4;
    localparam int          NUM_INSTR    = 2000;
    localparam int          RESET_CYCLES = 16;
    // NOP enters on edge 1 and issues on edge 3
    localparam int          NOP_ISSUE_EDGE = 3;
    // Fetch sampled on edge N is read and issued on edge N+2
    localparam int          READ_OFFSET  = 2;
    localparam int          RUN_LIMIT    = 10 * NUM_INSTR;

    // One expected issue bundle
    typedef struct packed {
        logic [31:0]           read_edge;
        logic [2:0]            unit;
        logic                  iop;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs1_used;
        logic                  rs2_used;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
    } item_t;

    logic                   clk;
    logic                   reset;
    logic                   fetch_valid;
    logic [XLEN-1:0]        fetch_instr;
    logic [XLEN-1:0]        fetch_pc;
    logic                   wb_valid;
    logic [REG_ADDR_W-1:0]  wb_rd;
    logic [XLEN-1:0]        wb_data;
    logic                   issue_valid;
    unit_t                  issue_unit;
    logic                   issue_iop;
    logic [2:0]             issue_funct3;
    logic [REG_ADDR_W-1:0]  issue_rd;
    logic signed [XLEN-1:0] issue_imm;
    logic [XLEN-1:0]        issue_pc;
    logic [XLEN-1:0]        issue_rs1_data;
    logic [XLEN-1:0]        issue_rs2_data;

    // Model state
    logic [XLEN-1:0] shadow [NUM_REGS];
    item_t           pend_q [$];
    item_t           issue_q [$];

    tb_clock_gen u_clock (
        .o_clk (clk)
    );

    decode_stage_top u_dut (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_fetch_valid    (fetch_valid),
        .i_fetch_instr    (fetch_instr),
        .i_fetch_pc       (fetch_pc),
        .i_wb_valid       (wb_valid),
        .i_wb_rd          (wb_rd),
        .i_wb_data        (wb_data),
        .o_issue_valid    (issue_valid),
        .o_issue_unit     (issue_unit),
        .o_issue_iop      (issue_iop),
        .o_issue_funct3   (issue_funct3),
        .o_issue_rd       (issue_rd),
        .o_issue_imm      (issue_imm),
        .o_issue_pc       (issue_pc),
        .o_issue_rs1_data (issue_rs1_data),
        .o_issue_rs2_data (issue_rs2_data)
    );

    ////////////////////
    // Reporting

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR %s actual 0x%08h expected 0x%08h", name, actual, expected);
            abort_run("Issue output mismatch");
        end
    endtask

    ////////////////////
    // Reference model

    // RV32I formats applied per family
    function automatic item_t model_decode(input logic [31:0] w, input logic [31:0] pc);
        item_t it;
        it        = '0;
        it.pc     = pc;
        it.funct3 = w[14:12];
        case (w[6:0])
            // LUI and AUIPC
            7'b0110111, 7'b0010111:
            begin
                it.unit = UNIT_UPPER;
                it.iop  = w[5];
                it.rd   = w[11:7];
                it.imm  = {w[31:12], 12'h000};
            end
            // JAL and JALR
            7'b1101111, 7'b1100111:
            begin
                it.unit = UNIT_JUMP;
                it.iop  = w[3];
                it.rd   = w[11:7];
                it.imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100011:
            begin
                it.unit     = UNIT_BRANCH;
                it.rs1      = w[19:15];
                it.rs2      = w[24:20];
                it.rs1_used = 1'b1;
                it.rs2_used = 1'b1;
                it.imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            // Load
            7'b0000011:
            begin
                it.unit     = UNIT_MEM;
                it.rd       = w[11:7];
                it.rs1      = w[19:15];
                it.rs1_used = 1'b1;
                it.imm      = {{20{w[31]}}, w[31:20]};
            end
            // Store sets iop
            7'b0100011:
            begin
                it.unit     = UNIT_MEM;
                it.iop      = 1'b1;
                it.rs1      = w[19:15];
                it.rs2      = w[24:20];
                it.rs1_used = 1'b1;
                it.rs2_used = 1'b1;
                it.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'b0010011:
            begin
                it.unit     = UNIT_ALU_IMM;
                it.iop      = w[30];
                it.rd       = w[11:7];
                it.rs1      = w[19:15];
                it.rs1_used = 1'b1;
                it.imm      = {{20{w[31]}}, w[31:20]};
            end
            7'b0110011:
            begin
                it.unit     = UNIT_ALU_REG;
                it.iop      = w[30];
                it.rd       = w[11:7];
                it.rs1      = w[19:15];
                it.rs2      = w[24:20];
                it.rs1_used = 1'b1;
                it.rs2_used = 1'b1;
            end
            // Nothing but the pc survives
            default:
            begin
                it.unit   = UNIT_ILLEGAL;
                it.funct3 = 3'b000;
            end
        endcase
        return it;
    endfunction

    // Random word of a random family including illegal ones
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        logic [6:0]  opc;
        w = $urandom();
        case ($urandom_range(0, 9))
            0: opc = 7'b0110111;
            1: opc = 7'b0010111;
            2: opc = 7'b1101111;
            3: opc = 7'b1100111;
            4: opc = 7'b1100011;
            5: opc = 7'b0000011;
            6: opc = 7'b0100011;
            7: opc = 7'b0010011;
            8: opc = 7'b0110011;
            default:
            begin
                // System, fence, AMO or low bits other than 11
                case ($urandom_range(0, 3))
                    0: opc = 7'b1110011;
                    1: opc = 7'b0001111;
                    2: opc = 7'b0101111;
                    default:
                    begin
                        opc      = 7'($urandom());
                        opc[1:0] = 2'($urandom_range(0, 2));
                    end
                endcase
            end
        endcase
        // Squeeze sources into x0..x7 half the time for more bypass hits
        if ($urandom_range(0, 1) == 1)
        begin
            w[19:18] = 2'b00;
            w[24:23] = 2'b00;
        end
        w[6:0] = opc;
        return w;
    endfunction

    // Reads see every writeback up to and including this edge
    task automatic resolve_operands(input int e);
        item_t it;
        if (pend_q.size() != 0 && pend_q[0].read_edge == e)
        begin
            it = pend_q.pop_front();
            it.rs1_data = (it.rs1_used && it.rs1 != '0) ? shadow[it.rs1] : '0;
            it.rs2_data = (it.rs2_used && it.rs2 != '0) ? shadow[it.rs2] : '0;
            issue_q.push_back(it);
        end
    endtask

    // Compare what the DUT issued on edge e
    task automatic check_issue(input int e);
        item_t want;
        if (issue_q.size() != 0 && issue_q[0].read_edge == e)
        begin
            want = issue_q.pop_front();
            check_value("o_issue_valid", 32'(issue_valid), 32'd1);
            check_value("o_issue_unit", 32'(issue_unit), 32'(want.unit));
            check_value("o_issue_iop", 32'(issue_iop), 32'(want.iop));
            check_value("o_issue_funct3", 32'(issue_funct3), 32'(want.funct3));
            check_value("o_issue_rd", 32'(issue_rd), 32'(want.rd));
            check_value("o_issue_imm", issue_imm, want.imm);
            check_value("o_issue_pc", issue_pc, want.pc);
            check_value("o_issue_rs1_data", issue_rs1_data, want.rs1_data);
            check_value("o_issue_rs2_data", issue_rs2_data, want.rs2_data);
        end
        else
            check_value("o_issue_valid", 32'(issue_valid), 32'd0);
    endtask

    ////////////////////
    // Stimulus

    initial
    begin
        item_t       it;
        logic [31:0] next_pc;
        int          fetched;
        int          edge_no;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc    = '0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        next_pc     = 32'h0000_1000;
        fetched     = 0;
        for (int r = 0; r < NUM_REGS; r++)
            shadow[r] = '0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        edge_no = 1;

        // Each pass sits at the falling edge ahead of edge_no
        while (fetched < NUM_INSTR || pend_q.size() != 0 || issue_q.size() != 0)
        begin
            if (edge_no > RUN_LIMIT)
                abort_run("Timeout while waiting for all instructions to issue");
            // NOP after reset is an ALU immediate op on x0 with a zero immediate
            if (edge_no - 1 == NOP_ISSUE_EDGE)
            begin
                check_value("o_issue_valid", 32'(issue_valid), 32'd1);
                check_value("o_issue_unit", 32'(issue_unit), 32'(UNIT_ALU_IMM));
                check_value("o_issue_rd", 32'(issue_rd), 32'd0);
                check_value("o_issue_imm", issue_imm, 32'd0);
                check_value("o_issue_pc", issue_pc, RESET_VECTOR);
            end
            check_issue(edge_no - 1);

            if (edge_no == 1)
            begin
                // Lost to the NOP that owns this slot
                fetch_valid = 1'b1;
                fetch_instr = random_instr();
                fetch_pc    = 32'hffff_fff0;
                it = model_decode(NOP_WORD, RESET_VECTOR);
                it.read_edge = edge_no + READ_OFFSET;
                pend_q.push_back(it);
            end
            else if (fetched < NUM_INSTR && $urandom_range(0, 99) < 60)
            begin
                fetch_valid = 1'b1;
                fetch_instr = random_instr();
                fetch_pc    = next_pc;
                it = model_decode(fetch_instr, fetch_pc);
                it.read_edge = edge_no + READ_OFFSET;
                pend_q.push_back(it);
                next_pc = next_pc + 32'd4;
                fetched++;
            end
            else
                fetch_valid = 1'b0;

            // Writeback lands on edge_no and may target x0
            wb_valid = ($urandom_range(0, 1) == 1);
            wb_rd    = ($urandom_range(0, 3) == 0) ? 5'($urandom()) : 5'($urandom_range(0, 7));
            wb_data  = $urandom();
            if (wb_valid && wb_rd != '0)
                shadow[wb_rd] = wb_data;
            resolve_operands(edge_no);

            @(negedge clk);
            edge_no++;
        end

        // Nothing more may come out
        check_issue(edge_no - 1);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== flist.f ====
design/rv_decode_pkg.sv
design/fetch_capture.sv
design/instruction_decoder.sv
design/operand_read.sv
design/decode_stage_top.sv
tb/tb_clock_gen.sv
tb/decode_assert.sv
tb/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module decode_tb \
    -f flist.f -Mdir obj_dir -o decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
else
    exit 1
fi
